// ==== source/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;

    // fixed attributes of every read burst
    localparam logic [1:0] burst_incr    = 2'b01;
    localparam logic [1:0] lock_normal   = 2'b00;
    localparam logic [3:0] cache_default = 4'b0000;
    localparam logic [2:0] prot_default  = 3'b000;

    // transaction ids per cpu port
    localparam logic [id_w-1:0] id_inst = 4'd0;
    localparam logic [id_w-1:0] id_data = 4'd1;

    // 4 byte transfer
    localparam logic [2:0] size_word = 3'd2;

endpackage

`default_nettype wire

// ==== source/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } bridge_state_t;

    // which cpu port owns the current transaction
    typedef enum logic {
        src_inst,
        src_data
    } req_src_t;

endpackage

`default_nettype wire

// ==== source/read_ctrl.sv ====
`default_nettype none

module read_ctrl
    import bridge_pkg::*;
#(
    parameter int pend_w = 5
) (
    input  wire logic              clk,
    input  wire logic              resetn,

    input  wire logic              inst_req,
    input  wire logic              data_req,
    input  wire logic [pend_w-1:0] pending_writes,

    input  wire logic              ar_done,
    input  wire logic              burst_done,

    output logic                   inst_addr_ok,
    output logic                   data_addr_ok,
    output logic                   load,
    output req_src_t               grant_src,
    output logic                   data_phase
);

    bridge_state_t state;
    bridge_state_t state_nxt;
    req_src_t      src_q;
    logic          data_eligible;
    logic          idle;

    // a read must not pass a store still in flight
    assign data_eligible = data_req && (pending_writes == '0);
    assign idle          = (state == st_idle);

    // grants answer the cpu in the same cycle
    assign data_addr_ok = idle && data_eligible;
    assign inst_addr_ok = idle && inst_req && !data_eligible;
    assign load         = data_addr_ok || inst_addr_ok;

    // live choice while idle, held owner for the rest of the transaction
    assign grant_src  = idle ? (data_eligible ? src_data : src_inst) : src_q;
    assign data_phase = (state == st_data);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (load) begin
                    state_nxt = st_addr;
                end
            end
            st_addr: begin
                if (ar_done) begin
                    state_nxt = st_data;
                end
            end
            st_data: begin
                if (burst_done) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
            src_q <= src_inst;
        end else begin
            state <= state_nxt;
            if (load) begin
                src_q <= grant_src;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/ar_channel.sv ====
`default_nettype none

module ar_channel
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              resetn,

    input  wire logic              load,
    input  wire req_src_t          grant_src,

    input  wire logic [addr_w-1:0] inst_addr,
    input  wire logic [len_w-1:0]  inst_len,
    input  wire logic [addr_w-1:0] data_addr,
    input  wire logic [2:0]        data_size,
    input  wire logic [len_w-1:0]  data_len,

    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [len_w-1:0]       arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic [1:0]             arlock,
    output logic [3:0]             arcache,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  wire logic              arready,
    output logic                   ar_done
);

    assign arburst = burst_incr;
    assign arlock  = lock_normal;
    assign arcache = cache_default;
    assign arprot  = prot_default;

    assign ar_done = arvalid && arready;

    // request fields, frozen from load until the next grant
    always_ff @(posedge clk) begin
        if (load) begin
            if (grant_src == src_data) begin
                arid   <= id_data;
                araddr <= data_addr;
                arsize <= data_size;
                arlen  <= data_len;
            end else begin
                // instruction fetches are always full words
                arid   <= id_inst;
                araddr <= inst_addr;
                arsize <= size_word;
                arlen  <= inst_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            arvalid <= 1'b0;
        end else if (load) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/r_channel.sv ====
`default_nettype none

module r_channel
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              resetn,

    input  wire logic              data_phase,
    input  wire req_src_t          grant_src,

    input  wire logic [data_w-1:0] rdata,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   rready,

    output logic                   inst_rvalid,
    output logic [data_w-1:0]      inst_rdata,
    output logic                   inst_rlast,
    output logic                   data_rvalid,
    output logic [data_w-1:0]      data_rdata,
    output logic                   data_rlast,

    output logic                   burst_done
);

    logic              beat;
    logic [data_w-1:0] rdata_q;
    logic              rlast_q;

    assign rready     = data_phase;
    assign beat       = rvalid && rready;
    assign burst_done = beat && rlast;

    // one data register shared by both ports, only the strobes are steered
    assign inst_rdata = rdata_q;
    assign data_rdata = rdata_q;
    assign inst_rlast = inst_rvalid && rlast_q;
    assign data_rlast = data_rvalid && rlast_q;

    always_ff @(posedge clk) begin
        if (beat) begin
            rdata_q <= rdata;
            rlast_q <= rlast;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_rvalid <= 1'b0;
            data_rvalid <= 1'b0;
        end else begin
            inst_rvalid <= beat && (grant_src == src_inst);
            data_rvalid <= beat && (grant_src == src_data);
        end
    end

endmodule

`default_nettype wire

// ==== source/axi_read_bridge.sv ====
`default_nettype none

module axi_read_bridge
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int pend_w = 5
) (
    input  wire logic              clk,
    input  wire logic              resetn,

    // instruction port
    input  wire logic              inst_req,
    input  wire logic [addr_w-1:0] inst_addr,
    input  wire logic [len_w-1:0]  inst_len,
    output logic                   inst_addr_ok,
    output logic                   inst_rvalid,
    output logic [data_w-1:0]      inst_rdata,
    output logic                   inst_rlast,

    // data port
    input  wire logic              data_req,
    input  wire logic [addr_w-1:0] data_addr,
    input  wire logic [2:0]        data_size,
    input  wire logic [len_w-1:0]  data_len,
    output logic                   data_addr_ok,
    output logic                   data_rvalid,
    output logic [data_w-1:0]      data_rdata,
    output logic                   data_rlast,

    input  wire logic [pend_w-1:0] pending_writes,

    // axi read address
    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [len_w-1:0]       arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic [1:0]             arlock,
    output logic [3:0]             arcache,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  wire logic              arready,

    // axi read data, rid and rresp are not looked at
    input  wire logic [id_w-1:0]   rid,
    input  wire logic [data_w-1:0] rdata,
    input  wire logic [1:0]        rresp,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   rready
);

    logic     load;
    req_src_t grant_src;
    logic     ar_done;
    logic     data_phase;
    logic     burst_done;

    read_ctrl #(
        .pend_w(pend_w)
    ) u_read_ctrl (
        .clk, .resetn,
        .inst_req, .data_req, .pending_writes,
        .ar_done, .burst_done,
        .inst_addr_ok, .data_addr_ok,
        .load, .grant_src, .data_phase
    );

    ar_channel u_ar_channel (
        .clk, .resetn,
        .load, .grant_src,
        .inst_addr, .inst_len,
        .data_addr, .data_size, .data_len,
        .arid, .araddr, .arlen, .arsize, .arburst, .arlock, .arcache, .arprot,
        .arvalid, .arready, .ar_done
    );

    r_channel u_r_channel (
        .clk, .resetn,
        .data_phase, .grant_src,
        .rdata, .rlast, .rvalid, .rready,
        .inst_rvalid, .inst_rdata, .inst_rlast,
        .data_rvalid, .data_rdata, .data_rlast,
        .burst_done
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_bridge_asserts.sv ====
`default_nettype none

module tb_bridge_asserts
    import axi_pkg::*;
(
    input wire logic              clk,
    input wire logic              resetn,
    input wire logic              inst_addr_ok,
    input wire logic              data_addr_ok,
    input wire logic              arvalid,
    input wire logic              arready,
    input wire logic [addr_w-1:0] araddr,
    input wire logic [id_w-1:0]   arid,
    input wire logic              rready
);

    int fail_count = 0;

    // address beat must hold until the slave takes it
    a_ar_stable: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
    else begin
        $error("address channel changed while waiting for arready");
        fail_count++;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!resetn)
        !(inst_addr_ok && data_addr_ok))
    else begin
        $error("both ports granted in one cycle");
        fail_count++;
    end

    // arvalid marks st_addr and rready marks st_data
    a_grant_idle: assert property (@(posedge clk) disable iff (!resetn)
        (inst_addr_ok || data_addr_ok) |-> !arvalid && !rready)
    else begin
        $error("grant given while a transaction was open");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`default_nettype none

module tb_checker
    import axi_pkg::*;
#(
    parameter int pend_w = 5
) (
    input wire logic              clk,
    input wire logic              resetn,
    input wire logic              inst_req,
    input wire logic [addr_w-1:0] inst_addr,
    input wire logic [len_w-1:0]  inst_len,
    input wire logic              data_req,
    input wire logic [addr_w-1:0] data_addr,
    input wire logic [2:0]        data_size,
    input wire logic [len_w-1:0]  data_len,
    input wire logic [pend_w-1:0] pending_writes,
    input wire logic              inst_addr_ok,
    input wire logic              data_addr_ok,
    input wire logic              inst_rvalid,
    input wire logic [data_w-1:0] inst_rdata,
    input wire logic              inst_rlast,
    input wire logic              data_rvalid,
    input wire logic [data_w-1:0] data_rdata,
    input wire logic              data_rlast,
    input wire logic [id_w-1:0]   arid,
    input wire logic [addr_w-1:0] araddr,
    input wire logic [len_w-1:0]  arlen,
    input wire logic [2:0]        arsize,
    input wire logic [1:0]        arburst,
    input wire logic [1:0]        arlock,
    input wire logic [3:0]        arcache,
    input wire logic [2:0]        arprot,
    input wire logic              arvalid,
    input wire logic              arready,
    input wire logic              rready,
    output int                    value_errors,
    output int                    protocol_errors
);

    // granted requests waiting for their address beat
    // src 0 is inst and 1 is data
    logic              q_src[$];
    logic [addr_w-1:0] q_addr[$];
    logic [len_w-1:0]  q_len[$];
    logic [2:0]        q_size[$];

    bit                cur_open = 1'b0;
    logic              cur_src;
    logic [addr_w-1:0] cur_addr;
    logic [len_w-1:0]  cur_len;
    logic [len_w-1:0]  cur_beat;
    logic [2:0]        cur_size;
    bit                seen_req = 1'b0;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("at time %0t: %s", $time, what);
    endtask

    task automatic check_beat(input logic src, input string port,
                              input logic [data_w-1:0] rdata, input logic rlast);
        logic [31:0] expected;
        if (!cur_open) begin
            protocol_error({port, " port returned a beat with no open transaction"});
            return;
        end
        if (src != cur_src) begin
            protocol_error({port, " port received a beat owned by the other port"});
        end
        // slave returns the inverted beat address
        expected = ~(cur_addr + (32'(cur_beat) << cur_size));
        compare_field({port, "_rdata"}, expected, rdata);
        if (cur_beat == cur_len) begin
            if (!rlast) begin
                protocol_error({port, " port burst ended without rlast"});
            end
            cur_open = 1'b0;
        end else begin
            if (rlast) begin
                protocol_error({port, " port rlast came before the final beat"});
            end
            cur_beat++;
        end
    endtask

    always @(negedge clk) begin
        if (!resetn) begin
            seen_req = 1'b0;
        end else begin
            if (inst_req || data_req) begin
                seen_req = 1'b1;
            end else if (!seen_req && (arvalid || rready || inst_addr_ok || data_addr_ok
                                       || inst_rvalid || data_rvalid)) begin
                protocol_error("bridge outputs active after reset before any request");
            end

            if (data_addr_ok && pending_writes != '0) begin
                protocol_error("data read accepted while writes were pending");
            end
            if (inst_addr_ok && data_req && pending_writes == '0) begin
                protocol_error("instruction read granted over an eligible data read");
            end

            if (inst_addr_ok) begin
                q_src.push_back(1'b0);
                q_addr.push_back(inst_addr);
                q_len.push_back(inst_len);
                q_size.push_back(size_word);
            end
            if (data_addr_ok) begin
                q_src.push_back(1'b1);
                q_addr.push_back(data_addr);
                q_len.push_back(data_len);
                q_size.push_back(data_size);
            end

            if (arvalid && arready) begin
                if (q_src.size() == 0) begin
                    protocol_error("address handshake without a granted request");
                end else begin
                    if (cur_open) begin
                        protocol_error("new address issued before the previous burst finished");
                    end
                    cur_src  = q_src.pop_front();
                    cur_addr = q_addr.pop_front();
                    cur_len  = q_len.pop_front();
                    cur_size = q_size.pop_front();
                    cur_beat = '0;
                    cur_open = 1'b1;
                    compare_field("arid", cur_src ? 32'(id_data) : 32'(id_inst), 32'(arid));
                    compare_field("araddr", cur_addr, araddr);
                    compare_field("arlen", 32'(cur_len), 32'(arlen));
                    compare_field("arsize", 32'(cur_size), 32'(arsize));
                    compare_field("arburst", 32'(burst_incr), 32'(arburst));
                    compare_field("arlock", 32'(lock_normal), 32'(arlock));
                    compare_field("arcache", 32'(cache_default), 32'(arcache));
                    compare_field("arprot", 32'(prot_default), 32'(arprot));
                end
            end

            if (inst_rvalid && data_rvalid) begin
                protocol_error("beats on both ports in the same cycle");
            end
            if (inst_rvalid) begin
                check_beat(1'b0, "inst", inst_rdata, inst_rlast);
            end
            if (data_rvalid) begin
                check_beat(1'b1, "data", data_rdata, data_rlast);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top
    import axi_pkg::*;
();

    localparam int pend_w    = 5;
    localparam int max_lines = 64;

    logic              clk;
    logic              resetn         = 1'b0;
    logic              inst_req       = 1'b0;
    logic [addr_w-1:0] inst_addr      = '0;
    logic [len_w-1:0]  inst_len       = '0;
    logic              data_req       = 1'b0;
    logic [addr_w-1:0] data_addr      = '0;
    logic [2:0]        data_size      = '0;
    logic [len_w-1:0]  data_len       = '0;
    logic [pend_w-1:0] pending_writes = '0;

    logic              inst_addr_ok;
    logic              inst_rvalid;
    logic [data_w-1:0] inst_rdata;
    logic              inst_rlast;
    logic              data_addr_ok;
    logic              data_rvalid;
    logic [data_w-1:0] data_rdata;
    logic              data_rlast;

    logic [id_w-1:0]   arid;
    logic [addr_w-1:0] araddr;
    logic [len_w-1:0]  arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;
    logic [1:0]        arlock;
    logic [3:0]        arcache;
    logic [2:0]        arprot;
    logic              arvalid;
    logic              arready = 1'b0;
    logic [id_w-1:0]   rid     = '0;
    logic [data_w-1:0] rdata   = '0;
    logic [1:0]        rresp   = 2'b00;
    logic              rlast   = 1'b0;
    logic              rvalid  = 1'b0;
    logic              rready;

    // stimulus table
    logic              l_ireq[max_lines];
    logic [addr_w-1:0] l_iaddr[max_lines];
    logic [len_w-1:0]  l_ilen[max_lines];
    logic              l_dreq[max_lines];
    logic [addr_w-1:0] l_daddr[max_lines];
    logic [2:0]        l_dsize[max_lines];
    logic [len_w-1:0]  l_dlen[max_lines];
    logic [pend_w-1:0] l_pend[max_lines];
    logic [31:0]       l_clr[max_lines];
    int                num_lines    = 0;
    int                setup_errors = 0;
    int                value_errors;
    int                protocol_errors;
    int                cycles       = 0;
    int                limit        = 0;

    // slave model state
    integer            seed    = 84;
    bit                busy    = 1'b0;
    int                ar_wait = 0;
    int                r_wait  = 0;
    logic [addr_w-1:0] sl_addr;
    logic [len_w-1:0]  sl_len;
    logic [2:0]        sl_size;
    logic [len_w-1:0]  beat_n;
    logic              s_arvalid;
    logic              s_arready;
    logic              s_rvalid;
    logic              s_rready;
    logic              s_rlast;
    logic [addr_w-1:0] s_araddr;
    logic [len_w-1:0]  s_arlen;
    logic [2:0]        s_arsize;
    logic [id_w-1:0]   s_arid;

    tb_clock #(.period(40)) u_clock (.clk(clk));

    axi_read_bridge #(.pend_w(pend_w)) u_dut (.*);

    tb_checker #(.pend_w(pend_w)) u_checker (.*);

    bind axi_read_bridge tb_bridge_asserts u_asserts (
        .clk(clk), .resetn(resetn),
        .inst_addr_ok(inst_addr_ok), .data_addr_ok(data_addr_ok),
        .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .arid(arid), .rready(rready)
    );

    function automatic int next_stall();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    task automatic load_stimulus();
        int                fd;
        int                n;
        string             line;
        logic              ir;
        logic [addr_w-1:0] ia;
        logic [len_w-1:0]  il;
        logic              dr;
        logic [addr_w-1:0] da;
        logic [2:0]        ds;
        logic [len_w-1:0]  dl;
        logic [pend_w-1:0] pw;
        logic [31:0]       pc;
        fd = $fopen("tb/read_input.txt", "r");
        if (fd == 0) begin
            $display("stimulus file tb/read_input.txt could not be opened");
            setup_errors++;
            return;
        end
        while (!$feof(fd) && num_lines < max_lines) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", ir, ia, il, dr, da, ds, dl, pw, pc);
            if (n == 9) begin
                l_ireq[num_lines]  = ir;
                l_iaddr[num_lines] = ia;
                l_ilen[num_lines]  = il;
                l_dreq[num_lines]  = dr;
                l_daddr[num_lines] = da;
                l_dsize[num_lines] = ds;
                l_dlen[num_lines]  = dl;
                l_pend[num_lines]  = pw;
                l_clr[num_lines]   = pc;
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    // present one line and hold until every request in it has finished
    task automatic run_line(input int i);
        bit inst_open;
        bit data_open;
        bit i_ok;
        bit d_ok;
        int clr;
        @(posedge clk);
        inst_req       <= l_ireq[i];
        inst_addr      <= l_iaddr[i];
        inst_len       <= l_ilen[i];
        data_req       <= l_dreq[i];
        data_addr      <= l_daddr[i];
        data_size      <= l_dsize[i];
        data_len       <= l_dlen[i];
        pending_writes <= l_pend[i];
        clr       = int'(l_clr[i]);
        inst_open = l_ireq[i];
        data_open = l_dreq[i];
        while (inst_open || data_open) begin
            @(negedge clk);
            i_ok = inst_addr_ok;
            d_ok = data_addr_ok;
            if (inst_rvalid && inst_rlast) begin
                inst_open = 1'b0;
            end
            if (data_rvalid && data_rlast) begin
                data_open = 1'b0;
            end
            @(posedge clk);
            if (i_ok) begin
                inst_req <= 1'b0;
            end
            if (d_ok) begin
                data_req <= 1'b0;
            end
            if (clr > 0) begin
                clr--;
            end else begin
                pending_writes <= '0;
            end
        end
    endtask

    task automatic print_counts();
        $display("errors: value %0d, protocol %0d, assertion %0d, setup %0d",
                 value_errors, protocol_errors, u_dut.u_asserts.fail_count, setup_errors);
    endtask

    initial begin
        load_stimulus();
        limit = 200 * num_lines + 100;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);
        for (int i = 0; i < num_lines; i++) begin
            run_line(i);
        end
        repeat (4) @(posedge clk);
        print_counts();
        if (num_lines > 0 && value_errors == 0 && protocol_errors == 0 && setup_errors == 0
            && u_dut.u_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not complete within %0d cycles", limit);
            print_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    // slave looks at the bus mid cycle and answers on the next rising edge
    always @(negedge clk) begin
        s_arvalid = arvalid;
        s_arready = arready;
        s_araddr  = araddr;
        s_arlen   = arlen;
        s_arsize  = arsize;
        s_arid    = arid;
        s_rvalid  = rvalid;
        s_rready  = rready;
        s_rlast   = rlast;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy    = 1'b0;
            ar_wait = next_stall();
        end else if (!busy) begin
            if (s_arvalid && s_arready) begin
                arready <= 1'b0;
                rid     <= s_arid;
                busy    = 1'b1;
                sl_addr = s_araddr;
                sl_len  = s_arlen;
                sl_size = s_arsize;
                beat_n  = '0;
                r_wait  = next_stall();
            end else if (s_arvalid) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait--;
                end
            end
        end else begin
            if (s_rvalid && s_rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                r_wait = next_stall();
                if (s_rlast) begin
                    busy    = 1'b0;
                    ar_wait = next_stall();
                end else begin
                    beat_n++;
                end
            end else if (!s_rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= ~(sl_addr + (32'(beat_n) << sl_size));
                    rlast  <= (beat_n == sl_len);
                end else begin
                    r_wait--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/read_input.txt ====
# ireq iaddr ilen dreq daddr dsize dlen pending clr, all hex
# clr is the number of cycles before pending_writes drops to zero
1 00001000 03 0 00000000 0 00 00 0
0 00000000 00 1 00002001 0 00 00 0
0 00000000 00 1 00002010 1 02 00 0
0 00000000 00 1 00003000 2 07 00 0
1 00004000 01 1 00005000 2 01 00 0
1 00006000 02 1 00007000 2 00 03 14
0 00000000 00 1 00008000 1 03 01 8
1 0000a004 00 0 00000000 0 00 00 0
1 0000b000 0f 1 0000b800 0 03 00 0
1 0000c000 04 0 00000000 0 00 02 5
1 0000d000 03 1 0000e000 1 05 1f 1e
0 00000000 00 1 0000f00c 2 01 00 0

// ==== compile.f ====
source/axi_pkg.sv
source/bridge_pkg.sv
source/read_ctrl.sv
source/ar_channel.sv
source/r_channel.sv
source/axi_read_bridge.sv
tb/tb_clock.sv
tb/tb_bridge_asserts.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell cat compile.f)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
